// File: design/fpm_cfg.svh
`ifndef FPM_CFG_SVH
`define FPM_CFG_SVH

// bus and float word
`define FPM_DATA_W 32
`define FPM_ADDR_W 3

// register map
`define FPM_REG_OP_A   3'd0
`define FPM_REG_OP_B   3'd1
`define FPM_REG_START  3'd2
`define FPM_REG_RESULT 3'd3
`define FPM_REG_STATUS 3'd4

// single precision fields
`define FP_EXP_W    8
`define FP_FRAC_W   23
`define FP_EXP_BIAS 127
`define FP_EXP_MAX  255
`define FP_QNAN     32'h7FC0_0000

// launch to valid, in clock edges
`define FPM_PIPE_STAGES 3

`endif

// File: design/fpm_pkg.sv
`include "fpm_cfg.svh"

package fpm_pkg;

	// one float, also one bus word
	typedef logic [`FPM_DATA_W-1:0] fp_word_t;

	// register address on the slave port
	typedef logic [`FPM_ADDR_W-1:0] fpm_addr_t;

	// overflow, underflow, zero, nan from msb down
	typedef logic [3:0] fpm_flags_t;

	// fraction with hidden bit in front
	typedef logic [`FP_FRAC_W:0] fp_sig_t;

	// full significand product, 2 x 24 bits
	typedef logic [2*`FP_FRAC_W+1:0] fp_prod_t;

	// two guard bits above the field so the sum of two biased
	// exponents minus the bias fits, sign included
	typedef logic signed [`FP_EXP_W+1:0] fp_exp_ext_t;

	// operand class, subnormals fold into zero
	typedef enum logic [1:0] {
		FP_ZERO,
		FP_NORMAL,
		FP_INF,
		FP_NAN
	} fp_class_t;

	// bus controller states
	typedef enum logic {
		ST_IDLE,
		ST_RUN
	} fpm_state_t;

endpackage

// File: design/fpm_bus_ctrl.sv
`timescale 1ns/1ps
`include "fpm_cfg.svh"

module fpm_bus_ctrl (
	input  logic              clk,
	input  logic              reset,
	input  fpm_pkg::fpm_addr_t i_address,
	input  logic              i_write,
	input  logic              i_valid,
	output logic              o_waitrequest,
	output logic              o_ld_op_a,
	output logic              o_ld_op_b,
	output logic              o_ld_result,
	output logic              o_launch
);
	import fpm_pkg::*;

	fpm_state_t state;
	fpm_state_t state_nxt;

	// write decode
	logic wr_op_a;
	logic wr_op_b;
	logic wr_start;

	assign wr_op_a  = i_write && (i_address == `FPM_REG_OP_A);
	assign wr_op_b  = i_write && (i_address == `FPM_REG_OP_B);
	assign wr_start = i_write && (i_address == `FPM_REG_START);

	// state register
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= ST_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// next state and strobes
	always_comb begin
		state_nxt     = state;
		o_waitrequest = 1'b0;
		o_ld_op_a     = 1'b0;
		o_ld_op_b     = 1'b0;
		o_ld_result   = 1'b0;
		o_launch      = 1'b0;

		case (state)
			ST_IDLE: begin
				// operand writes finish in one cycle
				o_ld_op_a = wr_op_a;
				o_ld_op_b = wr_op_b;
				// start write: stall master right away and fire the pipe
				if (wr_start) begin
					o_launch      = 1'b1;
					o_waitrequest = 1'b1;
					state_nxt     = ST_RUN;
				end
				// writes to result, status and holes just complete
			end

			ST_RUN: begin
				// master still holds the start write here
				if (i_valid) begin
					// waitrequest drops, write completes on this edge
					o_ld_result = 1'b1;
					state_nxt   = ST_IDLE;
				end else begin
					o_waitrequest = 1'b1;
				end
			end

			default: begin
				state_nxt = ST_IDLE;
			end
		endcase
	end

endmodule

// File: design/fpm_csr_bank.sv
`timescale 1ns/1ps
`include "fpm_cfg.svh"

module fpm_csr_bank (
	input  logic                clk,
	input  logic                reset,
	input  fpm_pkg::fpm_addr_t  i_address,
	input  logic                i_read,
	input  fpm_pkg::fp_word_t   i_writedata,
	input  logic                i_ld_op_a,
	input  logic                i_ld_op_b,
	input  logic                i_ld_result,
	input  fpm_pkg::fp_word_t   i_product,
	input  fpm_pkg::fpm_flags_t i_flags,
	output fpm_pkg::fp_word_t   o_op_a,
	output fpm_pkg::fp_word_t   o_op_b,
	output fpm_pkg::fp_word_t   o_readdata
);
	import fpm_pkg::*;

	// stored registers
	fp_word_t   op_a_q;
	fp_word_t   op_b_q;
	fp_word_t   result_q;
	fpm_flags_t status_q;

	// status as a full bus word
	fp_word_t   status_word;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			op_a_q   <= '0;
			op_b_q   <= '0;
			result_q <= '0;
			status_q <= '0;
		end else begin
			if (i_ld_op_a) begin
				op_a_q <= i_writedata;
			end
			if (i_ld_op_b) begin
				op_b_q <= i_writedata;
			end
			// result and flags always land together
			if (i_ld_result) begin
				result_q <= i_product;
				status_q <= i_flags;
			end
		end
	end

	// flags sit in bits 3..0, rest reads zero
	assign status_word = {{(`FPM_DATA_W - $bits(fpm_flags_t)){1'b0}}, status_q};

	// read mux, same cycle, never waits
	always_comb begin
		o_readdata = '0;
		if (i_read) begin
			case (i_address)
				`FPM_REG_OP_A:   o_readdata = op_a_q;
				`FPM_REG_OP_B:   o_readdata = op_b_q;
				`FPM_REG_RESULT: o_readdata = result_q;
				`FPM_REG_STATUS: o_readdata = status_word;
				// start and unmapped read zero
				default:         o_readdata = '0;
			endcase
		end
	end

	// operands straight to the multiplier
	assign o_op_a = op_a_q;
	assign o_op_b = op_b_q;

endmodule

// File: design/fp_mult_classify.sv
`timescale 1ns/1ps
`include "fpm_cfg.svh"

module fp_mult_classify (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 i_launch,
	input  fpm_pkg::fp_word_t    i_op_a,
	input  fpm_pkg::fp_word_t    i_op_b,
	output logic                 o_valid,
	output logic                 o_sign,
	output fpm_pkg::fp_exp_ext_t o_exp_sum,
	output fpm_pkg::fp_sig_t     o_sig_a,
	output fpm_pkg::fp_sig_t     o_sig_b,
	output logic                 o_special,
	output fpm_pkg::fp_word_t    o_special_word,
	output fpm_pkg::fpm_flags_t  o_special_flags
);
	import fpm_pkg::*;

	// exponent zero counts as zero, subnormals included
	function automatic fp_class_t classify(input fp_word_t op);
		logic [`FP_EXP_W-1:0]  exp_f;
		logic [`FP_FRAC_W-1:0] frac_f;
		exp_f  = op[`FP_FRAC_W +: `FP_EXP_W];
		frac_f = op[`FP_FRAC_W-1:0];
		if (exp_f == '0) begin
			return FP_ZERO;
		end else if (exp_f == `FP_EXP_W'(`FP_EXP_MAX)) begin
			return (frac_f == '0) ? FP_INF : FP_NAN;
		end
		return FP_NORMAL;
	endfunction

	fp_class_t   class_a;
	fp_class_t   class_b;
	logic        sign_c;
	logic        special_c;
	fp_word_t    special_word_c;
	fpm_flags_t  special_flags_c;
	fp_exp_ext_t exp_sum_c;

	assign class_a = classify(i_op_a);
	assign class_b = classify(i_op_b);
	assign sign_c  = i_op_a[`FPM_DATA_W-1] ^ i_op_b[`FPM_DATA_W-1];

	// biased sum minus one bias, can go negative
	assign exp_sum_c = fp_exp_ext_t'({2'b00, i_op_a[`FP_FRAC_W +: `FP_EXP_W]})
		+ fp_exp_ext_t'({2'b00, i_op_b[`FP_FRAC_W +: `FP_EXP_W]})
		- fp_exp_ext_t'(`FP_EXP_BIAS);

	// every non-normal pair is settled here
	always_comb begin
		special_c       = 1'b1;
		special_word_c  = '0;
		special_flags_c = '0;
		if (class_a == FP_NAN || class_b == FP_NAN
			|| (class_a == FP_INF && class_b == FP_ZERO)
			|| (class_a == FP_ZERO && class_b == FP_INF)) begin
			// nan flag only
			special_word_c  = `FP_QNAN;
			special_flags_c = 4'b0001;
		end else if (class_a == FP_INF || class_b == FP_INF) begin
			// signed inf, no flags
			special_word_c = {sign_c, {`FP_EXP_W{1'b1}}, {`FP_FRAC_W{1'b0}}};
		end else if (class_a == FP_ZERO || class_b == FP_ZERO) begin
			// signed zero, zero flag
			special_word_c  = {sign_c, {(`FPM_DATA_W-1){1'b0}}};
			special_flags_c = 4'b0010;
		end else begin
			special_c = 1'b0;
		end
	end

	// valid bit follows launch
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= i_launch;
		end
	end

	// payload, loaded every cycle
	always_ff @(posedge clk) begin
		o_sign          <= sign_c;
		o_exp_sum       <= exp_sum_c;
		o_sig_a         <= {1'b1, i_op_a[`FP_FRAC_W-1:0]};
		o_sig_b         <= {1'b1, i_op_b[`FP_FRAC_W-1:0]};
		o_special       <= special_c;
		o_special_word  <= special_word_c;
		o_special_flags <= special_flags_c;
	end

endmodule

// File: design/fp_mult_normalize.sv
`timescale 1ns/1ps
`include "fpm_cfg.svh"

module fp_mult_normalize (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 i_valid,
	input  logic                 i_sign,
	input  fpm_pkg::fp_exp_ext_t i_exp_sum,
	input  fpm_pkg::fp_sig_t     i_sig_a,
	input  fpm_pkg::fp_sig_t     i_sig_b,
	input  logic                 i_special,
	input  fpm_pkg::fp_word_t    i_special_word,
	input  fpm_pkg::fpm_flags_t  i_special_flags,
	output logic                 o_valid,
	output fpm_pkg::fp_word_t    o_product,
	output fpm_pkg::fpm_flags_t  o_flags
);
	import fpm_pkg::*;

	// stage 2 registers
	logic        s2_valid;
	logic        s2_sign;
	fp_exp_ext_t s2_exp_sum;
	fp_prod_t    s2_prod;
	logic        s2_special;
	fp_word_t    s2_special_word;
	fpm_flags_t  s2_special_flags;

	// stage 3 combinational
	logic [`FP_FRAC_W-1:0] frac_c;
	fp_exp_ext_t           exp_norm_c;
	fp_word_t              word_c;
	fpm_flags_t            flags_c;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			s2_valid <= 1'b0;
		end else begin
			s2_valid <= i_valid;
		end
	end

	// 24 x 24 product plus carried fields
	always_ff @(posedge clk) begin
		s2_sign          <= i_sign;
		s2_exp_sum       <= i_exp_sum;
		s2_prod          <= i_sig_a * i_sig_b;
		s2_special       <= i_special;
		s2_special_word  <= i_special_word;
		s2_special_flags <= i_special_flags;
	end

	// product lies in [1,4), top bit picks the shift
	always_comb begin
		if (s2_prod[2*`FP_FRAC_W+1]) begin
			frac_c     = s2_prod[2*`FP_FRAC_W -: `FP_FRAC_W];
			exp_norm_c = s2_exp_sum + fp_exp_ext_t'(1);
		end else begin
			frac_c     = s2_prod[2*`FP_FRAC_W-1 -: `FP_FRAC_W];
			exp_norm_c = s2_exp_sum;
		end
	end

	// range check, lower bits just dropped (round toward zero)
	always_comb begin
		word_c  = {s2_sign, exp_norm_c[`FP_EXP_W-1:0], frac_c};
		flags_c = '0;
		if (s2_special) begin
			word_c  = s2_special_word;
			flags_c = s2_special_flags;
		end else if (exp_norm_c >= fp_exp_ext_t'(`FP_EXP_MAX)) begin
			// overflow to signed inf
			word_c  = {s2_sign, {`FP_EXP_W{1'b1}}, {`FP_FRAC_W{1'b0}}};
			flags_c = 4'b1000;
		end else if (exp_norm_c <= fp_exp_ext_t'(0)) begin
			// underflow flushes, zero flag too
			word_c  = {s2_sign, {(`FPM_DATA_W-1){1'b0}}};
			flags_c = 4'b0110;
		end
	end

	// stage 3 output registers
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= s2_valid;
		end
	end

	always_ff @(posedge clk) begin
		o_product <= word_c;
		o_flags   <= flags_c;
	end

endmodule

// File: design/fpm_peripheral.sv
`timescale 1ns/1ps

module fpm_peripheral (
	input  logic               clk,
	input  logic               reset,
	input  fpm_pkg::fpm_addr_t i_address,
	input  logic               i_read,
	input  logic               i_write,
	input  fpm_pkg::fp_word_t  i_writedata,
	output fpm_pkg::fp_word_t  o_readdata,
	output logic               o_waitrequest
);

	// controller strobes
	logic ld_op_a;
	logic ld_op_b;
	logic ld_result;
	logic launch;

	// operands out of the bank
	fpm_pkg::fp_word_t op_a;
	fpm_pkg::fp_word_t op_b;

	// stage 1 to stage 2
	logic                 s1_valid;
	logic                 s1_sign;
	fpm_pkg::fp_exp_ext_t s1_exp_sum;
	fpm_pkg::fp_sig_t     s1_sig_a;
	fpm_pkg::fp_sig_t     s1_sig_b;
	logic                 s1_special;
	fpm_pkg::fp_word_t    s1_special_word;
	fpm_pkg::fpm_flags_t  s1_special_flags;

	// pipe result
	logic                pipe_valid;
	fpm_pkg::fp_word_t   pipe_product;
	fpm_pkg::fpm_flags_t pipe_flags;

	fpm_bus_ctrl u_ctrl (
		.clk(clk), .reset(reset), .i_address(i_address), .i_write(i_write),
		.i_valid(pipe_valid), .o_waitrequest(o_waitrequest), .o_ld_op_a(ld_op_a),
		.o_ld_op_b(ld_op_b), .o_ld_result(ld_result), .o_launch(launch)
	);

	fpm_csr_bank u_bank (
		.clk(clk), .reset(reset), .i_address(i_address), .i_read(i_read),
		.i_writedata(i_writedata), .i_ld_op_a(ld_op_a), .i_ld_op_b(ld_op_b),
		.i_ld_result(ld_result), .i_product(pipe_product), .i_flags(pipe_flags),
		.o_op_a(op_a), .o_op_b(op_b), .o_readdata(o_readdata)
	);

	// stage 1
	fp_mult_classify u_classify (
		.clk(clk), .reset(reset), .i_launch(launch), .i_op_a(op_a), .i_op_b(op_b),
		.o_valid(s1_valid), .o_sign(s1_sign), .o_exp_sum(s1_exp_sum),
		.o_sig_a(s1_sig_a), .o_sig_b(s1_sig_b), .o_special(s1_special),
		.o_special_word(s1_special_word), .o_special_flags(s1_special_flags)
	);

	// stages 2 and 3
	fp_mult_normalize u_normalize (
		.clk(clk), .reset(reset), .i_valid(s1_valid), .i_sign(s1_sign),
		.i_exp_sum(s1_exp_sum), .i_sig_a(s1_sig_a), .i_sig_b(s1_sig_b),
		.i_special(s1_special), .i_special_word(s1_special_word),
		.i_special_flags(s1_special_flags), .o_valid(pipe_valid),
		.o_product(pipe_product), .o_flags(pipe_flags)
	);

endmodule

// File: testbench/fpm_assertions.sv
`timescale 1ns/1ps
`include "fpm_cfg.svh"

module fpm_assertions (
	input logic               clk,
	input logic               reset,
	input fpm_pkg::fpm_addr_t i_address,
	input logic               i_read,
	input logic               i_write,
	input fpm_pkg::fp_word_t  i_writedata,
	input fpm_pkg::fp_word_t  i_readdata,
	input logic               i_waitrequest
);
	import fpm_pkg::*;

	// failures so far, read by the testbench
	int fail_count = 0;

	// what the registers should hold
	fp_word_t    sh_op_a;
	fp_word_t    sh_op_b;
	fp_word_t    sh_result;
	fpm_flags_t  sh_flags;
	// stalled cycles in a row so far
	int unsigned wait_cnt;
	logic        wr_done;
	logic        start_done;

	// reference multiply, returns flags above the word
	function automatic logic [35:0] model_mult(input fp_word_t a, input fp_word_t b);
		logic [7:0]  ea;
		logic [7:0]  eb;
		logic [22:0] fa;
		logic [22:0] fb;
		logic        sign;
		logic        a_nan;
		logic        b_nan;
		logic        a_inf;
		logic        b_inf;
		logic        a_zero;
		logic        b_zero;
		logic [47:0] prod;
		logic [22:0] frac;
		int          e;
		ea     = a[30:23];
		eb     = b[30:23];
		fa     = a[22:0];
		fb     = b[22:0];
		sign   = a[31] ^ b[31];
		a_nan  = (ea == 8'hFF) && (fa != 0);
		b_nan  = (eb == 8'hFF) && (fb != 0);
		a_inf  = (ea == 8'hFF) && (fa == 0);
		b_inf  = (eb == 8'hFF) && (fb == 0);
		// exponent zero is zero, subnormal or not
		a_zero = (ea == 8'h00);
		b_zero = (eb == 8'h00);
		if (a_nan || b_nan || (a_inf && b_zero) || (a_zero && b_inf)) begin
			return {4'b0001, `FP_QNAN};
		end
		if (a_inf || b_inf) begin
			return {4'b0000, sign, 8'hFF, 23'h0};
		end
		if (a_zero || b_zero) begin
			return {4'b0010, sign, 31'h0};
		end
		prod = {1'b1, fa} * {1'b1, fb};
		e    = int'(ea) + int'(eb) - 127;
		// truncate, bits below the kept fraction are lost
		if (prod[47]) begin
			frac = prod[46:24];
			e    = e + 1;
		end else begin
			frac = prod[45:23];
		end
		if (e >= 255) begin
			return {4'b1000, sign, 8'hFF, 23'h0};
		end
		if (e <= 0) begin
			return {4'b0110, sign, 31'h0};
		end
		return {4'b0000, sign, e[7:0], frac};
	endfunction

	assign wr_done    = i_write && !i_waitrequest;
	assign start_done = wr_done && (i_address == `FPM_REG_START);

	// shadow registers follow completed writes only
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			sh_op_a   <= '0;
			sh_op_b   <= '0;
			sh_result <= '0;
			sh_flags  <= '0;
			wait_cnt  <= 0;
		end else begin
			wait_cnt <= i_waitrequest ? wait_cnt + 1 : 0;
			if (wr_done && i_address == `FPM_REG_OP_A) begin
				sh_op_a <= i_writedata;
			end
			if (wr_done && i_address == `FPM_REG_OP_B) begin
				sh_op_b <= i_writedata;
			end
			// result lands on the edge the start write completes
			if (start_done) begin
				{sh_flags, sh_result} <= model_mult(sh_op_a, sh_op_b);
			end
		end
	end

	// operand readback
	a_rd_op_a: assert property (@(posedge clk) disable iff (reset)
		(i_read && i_address == `FPM_REG_OP_A) |-> (i_readdata == sh_op_a))
		else begin
			$error("Fail %0t: op a read %h, expected %h", $time, i_readdata, sh_op_a);
			fail_count++;
		end

	a_rd_op_b: assert property (@(posedge clk) disable iff (reset)
		(i_read && i_address == `FPM_REG_OP_B) |-> (i_readdata == sh_op_b))
		else begin
			$error("Fail %0t: op b read %h, expected %h", $time, i_readdata, sh_op_b);
			fail_count++;
		end

	// product word against the model
	a_rd_result: assert property (@(posedge clk) disable iff (reset)
		(i_read && i_address == `FPM_REG_RESULT) |-> (i_readdata == sh_result))
		else begin
			$error("Fail %0t: result read %h, model %h", $time, i_readdata, sh_result);
			fail_count++;
		end

	a_rd_status: assert property (@(posedge clk) disable iff (reset)
		(i_read && i_address == `FPM_REG_STATUS) |-> (i_readdata == {28'd0, sh_flags}))
		else begin
			$error("Fail %0t: status read %h, model flags %b", $time, i_readdata, sh_flags);
			fail_count++;
		end

	// start and the holes above status read zero
	a_rd_zero: assert property (@(posedge clk) disable iff (reset)
		(i_read && (i_address == `FPM_REG_START || i_address > `FPM_REG_STATUS))
		|-> (i_readdata == '0))
		else begin
			$error("Fail %0t: read of address %0d gave %h, not zero", $time, i_address,
				i_readdata);
			fail_count++;
		end

	// only a pending start write may stall the bus
	a_wait_cause: assert property (@(posedge clk) disable iff (reset)
		i_waitrequest |-> (i_write && i_address == `FPM_REG_START))
		else begin
			$error("Fail %0t: waitrequest high without a start write", $time);
			fail_count++;
		end

	// never more than the pipe depth of stall
	a_wait_len: assert property (@(posedge clk) disable iff (reset)
		i_waitrequest |-> (wait_cnt < `FPM_PIPE_STAGES))
		else begin
			$error("Fail %0t: waitrequest high for %0d cycles", $time, wait_cnt + 1);
			fail_count++;
		end

	// start completes only after the full stall
	a_start_done: assert property (@(posedge clk) disable iff (reset)
		start_done |-> (wait_cnt == `FPM_PIPE_STAGES))
		else begin
			$error("Fail %0t: start write completed after %0d wait cycles", $time,
				wait_cnt);
			fail_count++;
		end

endmodule

bind fpm_peripheral fpm_assertions u_checks (
	.clk(clk), .reset(reset), .i_address(i_address), .i_read(i_read),
	.i_write(i_write), .i_writedata(i_writedata), .i_readdata(o_readdata),
	.i_waitrequest(o_waitrequest)
);

// File: testbench/fpm_tb.sv
`timescale 1ns/1ps
`include "fpm_cfg.svh"

module fpm_tb;
	import fpm_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int NUM_RANDOM = 40;

	// cycle budget of each test
	localparam int BUDGET_RESET   = 16;
	localparam int BUDGET_IDLE    = 24;
	localparam int BUDGET_RDBACK  = 32;
	localparam int BUDGET_TIMING  = 24;
	localparam int BUDGET_RANDOM  = 480;
	localparam int BUDGET_SPECIAL = 160;
	localparam int BUDGET_RANGE   = 80;
	localparam int BUDGET_TOTAL   = BUDGET_RESET + BUDGET_IDLE + BUDGET_RDBACK
		+ BUDGET_TIMING + BUDGET_RANDOM + BUDGET_SPECIAL + BUDGET_RANGE;
	localparam int WATCHDOG_NS    = 20 * BUDGET_TOTAL * CLK_PERIOD;

	logic      clk = 1'b0;
	logic      reset;
	fpm_addr_t i_address;
	logic      i_read;
	logic      i_write;
	fp_word_t  i_writedata;
	fp_word_t  o_readdata;
	logic      o_waitrequest;

	// random source and bookkeeping
	logic [31:0] lfsr_q;
	int          tests_run;
	int          tests_failed;
	int          fails_mark;

	fpm_peripheral i_dut (
		.clk(clk), .reset(reset), .i_address(i_address), .i_read(i_read),
		.i_write(i_write), .i_writedata(i_writedata), .o_readdata(o_readdata),
		.o_waitrequest(o_waitrequest)
	);

	always #(CLK_PERIOD/2) clk = ~clk;

	// fibonacci step with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one lfsr step per bit
	task automatic take_bits(input int n, output logic [31:0] bits);
		bits = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_q = lfsr_next(lfsr_q);
			bits   = {bits[30:0], lfsr_q[0]};
		end
	endtask

	// exponent 96..159 so products stay in range
	task automatic random_normal(output fp_word_t op);
		logic [31:0] bits;
		logic [7:0]  exp_f;
		take_bits(30, bits);
		exp_f = 8'd96 + {2'b00, bits[28:23]};
		op    = {bits[29], exp_f, bits[22:0]};
	endtask

	// request held until an edge with waitrequest low
	task automatic bus_write(input fpm_addr_t addr, input fp_word_t data);
		logic stalled;
		i_address   <= addr;
		i_writedata <= data;
		i_write     <= 1'b1;
		stalled = 1'b1;
		while (stalled) begin
			@(negedge clk);
			stalled = o_waitrequest;
			@(posedge clk);
		end
		i_write <= 1'b0;
	endtask

	// readdata is checked by the bound checker
	task automatic bus_read(input fpm_addr_t addr);
		logic stalled;
		i_address <= addr;
		i_read    <= 1'b1;
		stalled = 1'b1;
		while (stalled) begin
			@(negedge clk);
			stalled = o_waitrequest;
			@(posedge clk);
		end
		i_read <= 1'b0;
	endtask

	// operands, start, then both result registers
	task automatic multiply(input fp_word_t a, input fp_word_t b);
		bus_write(`FPM_REG_OP_A, a);
		bus_write(`FPM_REG_OP_B, b);
		bus_write(`FPM_REG_START, 32'd0);
		bus_read(`FPM_REG_RESULT);
		bus_read(`FPM_REG_STATUS);
	endtask

	task automatic read_all();
		for (int k = 0; k < 8; k++) begin
			bus_read(fpm_addr_t'(k));
		end
	endtask

	// counts checker errors since the last test
	task automatic end_test(input string name);
		int seen;
		@(negedge clk);
		seen = i_dut.u_checks.fail_count;
		tests_run++;
		if (seen != fails_mark) begin
			tests_failed++;
			$display("%0t ns: %s failed, %0d assertion errors", $time, name,
				seen - fails_mark);
		end else begin
			$display("%0t ns: %s passed", $time, name);
		end
		fails_mark = seen;
		@(posedge clk);
	endtask

	initial begin
		fp_word_t a;
		fp_word_t b;
		int       total_fails;
		reset        <= 1'b1;
		i_address    <= '0;
		i_read       <= 1'b0;
		i_write      <= 1'b0;
		i_writedata  <= '0;
		lfsr_q       = 32'd86341;
		tests_run    = 0;
		tests_failed = 0;
		fails_mark   = 0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);

		// everything zero out of reset
		read_all();
		end_test("reset_reads");

		random_normal(a);
		random_normal(b);
		bus_write(`FPM_REG_OP_A, a);
		bus_write(`FPM_REG_OP_B, b);
		read_all();
		end_test("operand_readback");

		// 1.5 x 2.0, then a second start right behind it
		multiply(32'h3FC0_0000, 32'h4000_0000);
		bus_write(`FPM_REG_START, 32'd0);
		bus_read(`FPM_REG_RESULT);
		end_test("start_timing");

		// back to back random normals
		for (int n = 0; n < NUM_RANDOM; n++) begin
			random_normal(a);
			random_normal(b);
			multiply(a, b);
		end
		end_test("random_normals");

		// nan, inf x zero, inf x finite, zero x finite
		multiply(32'h7F80_0001, 32'h3F80_0000);
		multiply(32'h3F80_0000, 32'hFFC0_0000);
		multiply(32'h7F80_0000, 32'h0000_0000);
		multiply(32'h8000_0000, 32'hFF80_0000);
		multiply(32'h7F80_0000, 32'hC000_0000);
		multiply(32'hFF80_0000, 32'h4060_0000);
		multiply(32'h0000_0000, 32'h40A0_0000);
		multiply(32'hC000_0000, 32'h8000_0000);
		// subnormal counts as zero
		multiply(32'h0040_0000, 32'h4000_0000);
		end_test("special_cases");

		// overflow on both signs
		multiply(32'h7F00_0000, 32'h7F00_0000);
		multiply(32'hFF00_0000, 32'h4000_0000);
		// underflow, then just above and just at the bottom
		multiply(32'h0080_0000, 32'h0080_0000);
		multiply(32'h2000_0000, 32'h9F00_0000);
		multiply(32'h3F80_0000, 32'h0080_0000);
		multiply(32'h3F00_0000, 32'h0080_0000);
		end_test("exponent_range");

		@(negedge clk);
		total_fails = i_dut.u_checks.fail_count;
		$display("tests run %0d, tests failed %0d, assertion errors %0d", tests_run,
			tests_failed, total_fails);
		if (tests_failed == 0 && total_fails == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	// stuck handshake ends up here
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the test sequence did not finish",
			WATCHDOG_NS);
		$display("TEST FAIL");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+design
design/fpm_pkg.sv
design/fpm_bus_ctrl.sv
design/fpm_csr_bank.sv
design/fp_mult_classify.sv
design/fp_mult_normalize.sv
design/fpm_peripheral.sv
testbench/fpm_assertions.sv
testbench/fpm_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module fpm_tb -Mdir obj_dir

out=$(./obj_dir/Vfpm_tb +verilator+error+limit+1000 2>&1 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "TEST PASS"; then
	exit 0
fi
exit 1
